// File: include/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Number of decoded requests the queue can hold.
// Busy is raised to the core when all of them are in use.
`define LSU_QUEUE_DEPTH 4

// Size of the SRAM behind the bus, in 32-bit words.
// The slave indexes it with address bits from bit 2 upward.
`define LSU_MEM_WORDS 1024

// Cycles the SRAM slave waits on a read or write address before it
// raises the matching ready.
`define LSU_SRAM_WAIT 2

`endif

// File: hdl/lsu_pkg.sv
package lsu_pkg;

  // Bit 3 marks a store and bits 1:0 give the access size.
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LBU = 4'b0100,
    LHU = 4'b0101,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } mem_op_e;

  typedef enum logic [2:0] {
    IDLE,
    READ_ADDR,
    READ_DATA,
    WRITE_ADDR,
    WRITE_DATA,
    WRITE_RESP,
    COMPLETE
  } lsu_state_e;

  // Request as the core presents it.
  typedef struct packed {
    mem_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } core_req_t;

  // Decoded request. Size is 0 for a byte, 1 for a halfword and 2 for a word.
  // Store data already sits in the byte lanes selected by wstrb.
  typedef struct packed {
    logic        is_store;
    logic        sext;
    logic [1:0]  size;
    logic [31:0] addr;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
  } lsu_req_t;

endpackage

// File: hdl/lsu_issue.sv
module lsu_issue (
  input  logic               clock,
  input  logic               reset,
  input  logic               req_valid,
  input  lsu_pkg::core_req_t req,
  output logic               push,
  output lsu_pkg::lsu_req_t  push_req,
  output logic               align_error
);
  import lsu_pkg::*;

  lsu_req_t   dec;
  logic       known;
  logic       misaligned;
  logic [3:0] base_strb;

  always_comb begin
    dec       = '0;
    known     = 1'b1;
    dec.addr  = req.addr;
    case (req.op)
      LB:  begin dec.sext = 1'b1; dec.size = 2'd0; end
      LH:  begin dec.sext = 1'b1; dec.size = 2'd1; end
      LW:  dec.size = 2'd2;
      LBU: dec.size = 2'd0;
      LHU: dec.size = 2'd1;
      SB:  begin dec.is_store = 1'b1; dec.size = 2'd0; end
      SH:  begin dec.is_store = 1'b1; dec.size = 2'd1; end
      SW:  begin dec.is_store = 1'b1; dec.size = 2'd2; end
      default: known = 1'b0;
    endcase

    case (dec.size)
      2'd0:    base_strb = 4'b0001;
      2'd1:    base_strb = 4'b0011;
      default: base_strb = 4'b1111;
    endcase
    dec.wstrb = base_strb << req.addr[1:0];

    // Replicating the store value puts it on every lane the strobe can pick.
    case (dec.size)
      2'd0:    dec.wdata = {4{req.wdata[7:0]}};
      2'd1:    dec.wdata = {2{req.wdata[15:0]}};
      default: dec.wdata = req.wdata;
    endcase

    misaligned = ((dec.size == 2'd1) && req.addr[0]) ||
                 ((dec.size == 2'd2) && (req.addr[1:0] != 2'b00));
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      push        <= 1'b0;
      align_error <= 1'b0;
    end else begin
      push        <= req_valid && known && !misaligned;
      align_error <= req_valid && known && misaligned;
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid) begin
      push_req <= dec;
    end
  end

endmodule

// File: hdl/lsu_req_queue.sv
`include "lsu_defines.svh"

module lsu_req_queue (
  input  logic              clock,
  input  logic              reset,
  input  logic              push,
  input  lsu_pkg::lsu_req_t push_req,
  input  logic              pop,
  output lsu_pkg::lsu_req_t head,
  output logic              empty,
  output logic              full
);
  import lsu_pkg::*;

  localparam int DEPTH = `LSU_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_req_t         entries [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = entries[rd_ptr];
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      entries[wr_ptr] <= push_req;
    end
  end

  // The core is expected to hold off while busy is high.
  a_no_push_when_full: assert property (@(posedge clock) disable iff (reset)
    push |-> !full)
    else $error("Request pushed into a full queue.");

  a_no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
    pop |-> !empty)
    else $error("Bus master popped an empty queue.");

endmodule

// File: hdl/lsu_bus_master.sv
module lsu_bus_master (
  input  logic              clock,
  input  logic              reset,
  input  lsu_pkg::lsu_req_t head,
  input  logic              empty,
  output logic              pop,
  output logic              load_done,
  output logic [31:0]       load_data,
  output logic              store_done,
  output logic [31:0]       araddr,
  output logic              arvalid,
  input  logic              arready,
  output logic              rready,
  input  logic [31:0]       rdata,
  input  logic [1:0]        rresp,
  input  logic              rvalid,
  output logic [31:0]       awaddr,
  output logic              awvalid,
  input  logic              awready,
  output logic [31:0]       wdata,
  output logic [3:0]        wstrb,
  output logic              wvalid,
  input  logic              wready,
  output logic              bready,
  input  logic [1:0]        bresp,
  input  logic              bvalid
);
  import lsu_pkg::*;

  lsu_state_e  state;
  lsu_req_t    cur;
  logic [31:0] lane;
  logic [31:0] load_ext;

  assign pop    = (state == IDLE) && !empty;
  assign araddr = cur.addr;
  assign awaddr = cur.addr;
  assign wdata  = cur.wdata;
  assign wstrb  = cur.wstrb;

  // Shift the addressed byte or halfword down to bit 0 before extending it.
  always_comb begin
    lane = rdata >> {cur.addr[1:0], 3'b000};
    case (cur.size)
      2'd0:    load_ext = cur.sext ? {{24{lane[7]}}, lane[7:0]} : {24'b0, lane[7:0]};
      2'd1:    load_ext = cur.sext ? {{16{lane[15]}}, lane[15:0]} : {16'b0, lane[15:0]};
      default: load_ext = rdata;
    endcase
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      cur <= head;
    end
    if ((state == READ_DATA) && rvalid && rready) begin
      load_data <= load_ext;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= IDLE;
      arvalid    <= 1'b0;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      rready     <= 1'b1;
      bready     <= 1'b1;
      load_done  <= 1'b0;
      store_done <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (!empty) begin
            if (head.is_store) begin
              awvalid <= 1'b1;
              state   <= WRITE_ADDR;
            end else begin
              arvalid <= 1'b1;
              state   <= READ_ADDR;
            end
          end
        end
        READ_ADDR: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= READ_DATA;
          end
        end
        READ_DATA: begin
          if (rvalid && rready) begin
            rready    <= 1'b0;
            load_done <= 1'b1;
            state     <= COMPLETE;
          end
        end
        WRITE_ADDR: begin
          // Data goes out only once the address has been taken.
          if (awvalid && awready) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b1;
            state   <= WRITE_DATA;
          end
        end
        WRITE_DATA: begin
          if (wvalid && wready) begin
            wvalid <= 1'b0;
            bready <= 1'b1;
            state  <= WRITE_RESP;
          end
        end
        WRITE_RESP: begin
          if (bvalid && bready) begin
            bready     <= 1'b0;
            store_done <= 1'b1;
            state      <= COMPLETE;
          end
        end
        COMPLETE: begin
          load_done  <= 1'b0;
          store_done <= 1'b0;
          state      <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_one_address_channel: assert property (@(posedge clock) disable iff (reset)
    !(arvalid && awvalid))
    else $error("Read and write address channels active together.");

endmodule

// File: hdl/lsu_sram_slave.sv
`include "lsu_defines.svh"

module lsu_sram_slave (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  input  logic        bready,
  output logic [1:0]  bresp,
  output logic        bvalid
);

  localparam int WORDS = `LSU_MEM_WORDS;
  localparam int IDX_W = $clog2(WORDS);
  localparam int WAIT  = `LSU_SRAM_WAIT;
  localparam int CNT_W = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

  logic [31:0]      mem [WORDS];
  logic [IDX_W-1:0] w_idx;
  logic [CNT_W-1:0] wait_cnt;
  logic             wait_done;
  logic             aw_pending;
  logic             ar_fire;
  logic             aw_fire;
  logic             w_fire;

  assign ar_fire   = arvalid && arready;
  assign aw_fire   = awvalid && awready;
  assign w_fire    = wvalid && wready;
  assign wait_done = (int'(wait_cnt) + 1 >= WAIT);
  assign rresp     = 2'b00;
  assign bresp     = 2'b00;

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_cnt   <= '0;
      arready    <= 1'b0;
      awready    <= 1'b0;
      rvalid     <= 1'b0;
      wready     <= 1'b0;
      bvalid     <= 1'b0;
      aw_pending <= 1'b0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      // Address readies are single-cycle pulses once the wait has elapsed.
      arready <= 1'b0;
      awready <= 1'b0;
      if ((arvalid || awvalid) && !arready && !awready) begin
        if (wait_done) begin
          wait_cnt <= '0;
          arready  <= arvalid;
          awready  <= awvalid;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
      end

      if (ar_fire) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end

      if (aw_fire) begin
        aw_pending <= 1'b1;
        wready     <= 1'b1;
      end

      if (w_fire) begin
        aw_pending <= 1'b0;
        wready     <= 1'b0;
        bvalid     <= 1'b1;
        for (int lane = 0; lane < 4; lane++) begin
          if (wstrb[lane]) begin
            mem[w_idx][8*lane +: 8] <= wdata[8*lane +: 8];
          end
        end
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata <= mem[araddr[2 +: IDX_W]];
    end
    if (aw_fire) begin
      w_idx <= awaddr[2 +: IDX_W];
    end
  end

  a_w_after_aw: assert property (@(posedge clock) disable iff (reset)
    wvalid |-> aw_pending)
    else $error("Write data presented before its address was accepted.");

endmodule

// File: hdl/lsu_top.sv
module lsu_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               req_valid,
  input  lsu_pkg::core_req_t req,
  output logic               busy,
  output logic               align_error,
  output logic               load_done,
  output logic [31:0]        load_data,
  output logic               store_done
);
  import lsu_pkg::*;

  logic        push;
  lsu_req_t    push_req;
  lsu_req_t    head;
  logic        empty;
  logic        pop;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic        bready;
  logic [1:0]  bresp;
  logic        bvalid;

  lsu_issue u_issue (
    .clock       (clock),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .push        (push),
    .push_req    (push_req),
    .align_error (align_error)
  );

  // Busy is simply the queue's full level.
  lsu_req_queue u_queue (
    .clock    (clock),
    .reset    (reset),
    .push     (push),
    .push_req (push_req),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .full     (busy)
  );

  lsu_bus_master u_master (
    .clock      (clock),
    .reset      (reset),
    .head       (head),
    .empty      (empty),
    .pop        (pop),
    .load_done  (load_done),
    .load_data  (load_data),
    .store_done (store_done),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bready     (bready),
    .bresp      (bresp),
    .bvalid     (bvalid)
  );

  lsu_sram_slave u_sram (
    .clock   (clock),
    .reset   (reset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bready  (bready),
    .bresp   (bresp),
    .bvalid  (bvalid)
  );

endmodule

// File: sim/lsu_tb.sv
`include "lsu_defines.svh"

module lsu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  localparam int MEM_BYTES      = 4 * `LSU_MEM_WORDS;
  localparam int WORD_REQS      = 8;
  localparam int MERGE_REQS     = 13;
  localparam int EXTEND_REQS    = 26;
  localparam int MISALIGN_REQS  = 13;
  localparam int BURST_REQS     = 24;
  localparam int RANDOM_REQS    = 200;
  localparam int TOTAL_REQS     = WORD_REQS + MERGE_REQS + EXTEND_REQS + MISALIGN_REQS +
                                  BURST_REQS + RANDOM_REQS;
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * 20 + 200;

  logic        clock = 1'b0;
  logic        reset;
  logic        req_valid;
  core_req_t   req;
  logic        busy;
  logic        align_error;
  logic        load_done;
  logic [31:0] load_data;
  logic        store_done;

  logic [7:0]  ref_mem [MEM_BYTES];
  mem_op_e     exp_op [$];
  logic [31:0] exp_data [$];
  string       exp_name [$];
  int          align_expected = 0;
  logic        saw_busy = 1'b0;
  logic [31:0] rng_state = 32'h8d16_297d;
  int          cycle_count = 0;

  lsu_top u_dut (
    .clock       (clock),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .busy        (busy),
    .align_error (align_error),
    .load_done   (load_done),
    .load_data   (load_data),
    .store_done  (store_done)
  );

  always #2 clock = ~clock;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic bit is_store(input mem_op_e op);
    return op inside {SB, SH, SW};
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic bit is_misaligned(input mem_op_e op, input logic [31:0] addr);
    return ((access_bytes(op) == 2) && addr[0]) ||
           ((access_bytes(op) == 4) && (addr[1:0] != 2'b00));
  endfunction

  // Memory is little-endian, so byte i of the store data lands at addr + i.
  function automatic void model_store(input mem_op_e op, input logic [31:0] addr,
                                      input logic [31:0] data);
    for (int i = 0; i < access_bytes(op); i++) begin
      ref_mem[int'(addr) + i] = data[8*i +: 8];
    end
  endfunction

  function automatic logic [31:0] expected_load(input mem_op_e op, input logic [31:0] addr);
    logic [31:0] raw;
    raw = '0;
    for (int i = 0; i < access_bytes(op); i++) begin
      raw[8*i +: 8] = ref_mem[int'(addr) + i];
    end
    case (op)
      LB:      return {{24{raw[7]}}, raw[7:0]};
      LH:      return {{16{raw[15]}}, raw[15:0]};
      default: return raw;
    endcase
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_load(input string name, input mem_op_e op, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (is_store(op)) begin
      abort_run($sformatf("Mismatch in %s: expected %s completion, actual load completion",
                          name, op.name()));
    end else if (actual !== expected) begin
      abort_run($sformatf("Mismatch in %s (%s): expected %08h, actual %08h",
                          name, op.name(), expected, actual));
    end
  endtask

  task automatic check_store(input string name, input mem_op_e op);
    if (!is_store(op)) begin
      abort_run($sformatf("Mismatch in %s: expected %s completion, actual store completion",
                          name, op.name()));
    end
  endtask

  task automatic send_request(input string name, input mem_op_e op, input logic [31:0] addr,
                              input logic [31:0] data);
    core_req_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = data;
    while (busy) begin
      @(posedge clock);
    end
    req_valid <= 1'b1;
    req       <= r;
    if (is_misaligned(op, addr)) begin
      align_expected++;
    end else begin
      exp_op.push_back(op);
      exp_name.push_back(name);
      if (is_store(op)) begin
        model_store(op, addr, data);
        exp_data.push_back(32'd0);
      end else begin
        exp_data.push_back(expected_load(op, addr));
      end
    end
    @(posedge clock);
    req_valid <= 1'b0;
    // Busy only counts a request once it has passed the issue register
    // and landed in the queue, two edges after the strobe.
    repeat (2) @(posedge clock);
  endtask

  task automatic send_random(input string name);
    logic [31:0] r;
    logic [31:0] addr;
    mem_op_e     op;
    r = next_rand();
    case (r[31:29])
      3'd0:    op = LB;
      3'd1:    op = LH;
      3'd2:    op = LW;
      3'd3:    op = LBU;
      3'd4:    op = LHU;
      3'd5:    op = SB;
      3'd6:    op = SH;
      default: op = SW;
    endcase
    addr = {22'd0, r[9:0]};
    if (access_bytes(op) >= 2) begin
      addr[0] = 1'b0;
    end
    if (access_bytes(op) == 4) begin
      addr[1] = 1'b0;
    end
    send_request(name, op, addr, next_rand());
  endtask

  task automatic wait_idle();
    while ((exp_op.size() != 0) || (align_expected != 0)) begin
      @(posedge clock);
    end
    // Quiet cycles so that a stray done pulse would still be seen.
    repeat (20) @(posedge clock);
  endtask

  always @(posedge clock) begin : compare
    mem_op_e     op;
    logic [31:0] data;
    string       name;
    if (!reset) begin
      if (busy) begin
        saw_busy = 1'b1;
      end
      if (load_done && store_done) begin
        abort_run("load_done and store_done pulsed in the same cycle");
      end else if (align_error && (align_expected == 0)) begin
        abort_run("align_error pulsed for a request that was aligned");
      end else if ((load_done || store_done) && (exp_op.size() == 0)) begin
        abort_run("A done pulse arrived with no request outstanding");
      end else begin
        if (align_error) begin
          align_expected--;
        end
        if (load_done || store_done) begin
          op   = exp_op.pop_front();
          data = exp_data.pop_front();
          name = exp_name.pop_front();
          if (load_done) begin
            check_load(name, op, data, load_data);
          end else begin
            check_store(name, op);
          end
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles with requests still pending",
                          TIMEOUT_CYCLES));
    end
  end

  initial begin : stimulus
    logic [31:0] addr;
    logic [31:0] data;
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    for (int i = 0; i < WORD_REQS / 2; i++) begin
      data = next_rand();
      addr = {20'd0, data[11:2], 2'b00};
      send_request("word store/load", SW, addr, next_rand());
      send_request("word store/load", LW, addr, 32'd0);
    end
    wait_idle();

    addr = 32'h100;
    send_request("lane merge", SW, addr, 32'h1122_3344);
    for (int off = 0; off < 4; off++) begin
      send_request("lane merge", SB, addr + off, next_rand());
      send_request("lane merge", LW, addr, 32'd0);
    end
    for (int off = 0; off < 4; off += 2) begin
      send_request("lane merge", SH, addr + off, next_rand());
      send_request("lane merge", LW, addr, 32'd0);
    end
    wait_idle();

    // The first word has the sign bit set in every byte, the second in none.
    addr = 32'h140;
    for (int w = 0; w < 2; w++) begin
      data = (w == 0) ? 32'h80ff_8081 : 32'h7f01_7f10;
      send_request("load extension", SW, addr, data);
      for (int off = 0; off < 4; off++) begin
        send_request("load extension", LB, addr + off, 32'd0);
        send_request("load extension", LBU, addr + off, 32'd0);
      end
      for (int off = 0; off < 4; off += 2) begin
        send_request("load extension", LH, addr + off, 32'd0);
        send_request("load extension", LHU, addr + off, 32'd0);
      end
    end
    wait_idle();

    addr = 32'h180;
    send_request("misaligned", SW, addr, 32'hcafe_f00d);
    send_request("misaligned", LH, addr + 1, 32'd0);
    send_request("misaligned", LH, addr + 3, 32'd0);
    send_request("misaligned", LHU, addr + 1, 32'd0);
    send_request("misaligned", SH, addr + 1, 32'hffff_ffff);
    send_request("misaligned", SH, addr + 3, 32'hffff_ffff);
    for (int off = 1; off < 4; off++) begin
      send_request("misaligned", LW, addr + off, 32'd0);
      send_request("misaligned", SW, addr + off, 32'hffff_ffff);
    end
    send_request("misaligned", LW, addr, 32'd0);
    wait_idle();

    saw_busy = 1'b0;
    for (int i = 0; i < 8; i++) begin
      send_request("burst", SW, 32'h200 + 4 * i, next_rand());
    end
    for (int i = 0; i < 8; i++) begin
      send_request("burst", LW, 32'h200 + 4 * i, 32'd0);
    end
    for (int i = 0; i < 8; i++) begin
      send_request("burst", LH, 32'h202 + 4 * i, 32'd0);
    end
    wait_idle();
    if (!saw_busy) begin
      abort_run("busy never went high during the back-to-back burst");
    end

    for (int i = 0; i < RANDOM_REQS; i++) begin
      send_random("random mix");
    end
    wait_idle();

    $display("Verification passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_issue.sv
hdl/lsu_req_queue.sv
hdl/lsu_bus_master.sv
hdl/lsu_sram_slave.sv
hdl/lsu_top.sv
sim/lsu_tb.sv

// File: Makefile
SRCS = $(wildcard hdl/*.sv) $(wildcard sim/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vlsu_tb: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f files.f

run: obj_dir/Vlsu_tb
	@out="$$(./obj_dir/Vlsu_tb)"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
